/* logic/arm_isa_pkg.sv */
package arm_isa_pkg;

	// ------------------------------------------------------------------------
	// operand two shift kinds, straight from instruction bits 6:5
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		lsl = 2'b00,    // logical left
		lsr = 2'b01,    // logical right
		asr = 2'b10,    // arithmetic right
		ror = 2'b11     // rotate right, rrx when the immediate amount is zero
	} shift_kind_t;

	// ------------------------------------------------------------------------
	// instruction classes seen by decode
	// ------------------------------------------------------------------------
	// alu_imm      data processing, 8-bit immediate rotated by 2*rot
	// alu_reg      data processing, shifted register operand
	// multiply     mul / mla, 32-bit result only
	// single_xfer  ldr / str
	// block_xfer   ldm / stm
	// branch       b / bl
	// swi          software interrupt
	// other        everything the front end does not decode
	typedef enum logic [2:0] {
		alu_imm     = 3'd0,
		alu_reg     = 3'd1,
		multiply    = 3'd2,
		single_xfer = 3'd3,
		block_xfer  = 3'd4,
		branch      = 3'd5,
		swi         = 3'd6,
		other       = 3'd7
	} insn_class_t;

	// carry flag position in the status word (n z c v from bit 31 down)
	localparam int cbit = 29;

	// r15 reads see the address of the instruction plus the pipeline offset
	localparam logic [31:0] pc_read_offset = 32'd8;

	// one extra word when the shift amount comes from Rs
	localparam logic [31:0] pc_read_offset_regshift = 32'd12;

	localparam logic [3:0] pc_reg = 4'd15;

endpackage

/* logic/arm_core_pkg.sv */
package arm_core_pkg;

	// data, instruction and address words are all 32 bits
	typedef logic [31:0] word_t;

	// register number, r0 .. r15
	typedef logic [3:0] reg_sel_t;

	// ------------------------------------------------------------------------
	// instruction queue sizing
	// ------------------------------------------------------------------------
	localparam int queue_depth = 4;
	localparam int queue_ptr_w = 2;    // log2 of queue_depth

	// first fetch address after reset
	localparam word_t reset_pc = 32'h0000_0000;

endpackage

/* logic/arm_fetch.sv */
`timescale 1ns/100ps

module arm_fetch (
	input  logic                clk,
	input  logic                rst,
	input  logic                redirect,
	input  arm_core_pkg::word_t redirect_pc,
	input  logic                full,
	output arm_core_pkg::word_t imem_addr,
	input  arm_core_pkg::word_t imem_data,
	output logic                push,
	output arm_core_pkg::word_t push_insn,
	output arm_core_pkg::word_t push_pc
);

	arm_core_pkg::word_t pc;
	logic                running;    // set by the first redirect after reset

	// fetch stays idle until a redirect gives it a start address
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
		end else if (redirect) begin
			running <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= arm_core_pkg::reset_pc;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (push) begin
			pc <= pc + 32'd4;    // next sequential word
		end
	end

	assign imem_addr = pc;

	// memory is combinational, so the word for pc is here this cycle
	assign push      = running && !full && !redirect;
	assign push_insn = imem_data;
	assign push_pc   = pc;

endmodule

/* logic/insn_queue.sv */
`timescale 1ns/100ps

module insn_queue (
	input  logic                clk,
	input  logic                rst,
	input  logic                flush,
	input  logic                push,
	input  arm_core_pkg::word_t push_insn,
	input  arm_core_pkg::word_t push_pc,
	output logic                full,
	input  logic                pop,
	output logic                head_valid,
	output arm_core_pkg::word_t head_insn,
	output arm_core_pkg::word_t head_pc
);

	arm_core_pkg::word_t insn_mem [arm_core_pkg::queue_depth];
	arm_core_pkg::word_t pc_mem [arm_core_pkg::queue_depth];

	logic [arm_core_pkg::queue_ptr_w-1:0] wr_ptr;
	logic [arm_core_pkg::queue_ptr_w-1:0] rd_ptr;
	logic [arm_core_pkg::queue_ptr_w:0]   count;    // one bit wider than the pointers
	logic                                 do_push;
	logic                                 do_pop;

	assign full       = (count == (arm_core_pkg::queue_ptr_w + 1)'(arm_core_pkg::queue_depth));
	assign head_valid = (count != '0) && !flush;    // hide wrong-path entries
	assign head_insn  = insn_mem[rd_ptr];
	assign head_pc    = pc_mem[rd_ptr];

	assign do_push = push && !full && !flush;
	assign do_pop  = pop && head_valid;

	// entry storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			insn_mem[wr_ptr] <= push_insn;
			pc_mem[wr_ptr]   <= push_pc;
		end
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;    // idle, or push and pop together
			endcase
		end
	end

endmodule

/* logic/arm_regfile.sv */
`timescale 1ns/100ps

module arm_regfile (
	input  logic        clk,
	input  logic        wr_en,
	input  logic [3:0]  wr_sel,
	input  logic [31:0] wr_data,
	input  logic [3:0]  rd_sel0,
	input  logic [3:0]  rd_sel1,
	input  logic [3:0]  rd_sel2,
	output logic [31:0] rd_data0,
	output logic [31:0] rd_data1,
	output logic [31:0] rd_data2
);

	logic [31:0] regs [15];    // r0 .. r14, r15 lives in decode

	// r15 reads back zero here
	function automatic logic [31:0] read_reg(input logic [3:0] sel);
		return (sel == 4'd15) ? 32'd0 : regs[sel];
	endfunction

	always_ff @(posedge clk) begin
		if (wr_en && (wr_sel != 4'd15))
			regs[wr_sel] <= wr_data;
	end

	// reads see the old value during a write cycle
	assign rd_data0 = read_reg(rd_sel0);
	assign rd_data1 = read_reg(rd_sel1);
	assign rd_data2 = read_reg(rd_sel2);

endmodule

/* logic/arm_shifter.sv */
`timescale 1ns/100ps

module arm_shifter (
	input  arm_core_pkg::word_t insn,
	input  arm_core_pkg::word_t operand,
	input  arm_core_pkg::word_t reg_amount,
	input  logic                carry_in,
	output arm_core_pkg::word_t result,
	output logic                carry_out
);

	arm_isa_pkg::shift_kind_t kind;
	logic                     by_reg;     // amount taken from Rs
	logic [7:0]               amt;
	logic [32:0]              lsl_wide;   // carry on top
	logic [32:0]              lsr_wide;   // carry at the bottom
	logic [32:0]              asr_wide;
	arm_core_pkg::word_t      ror_res;

	assign kind   = arm_isa_pkg::shift_kind_t'(insn[6:5]);
	assign by_reg = insn[4];

	// immediate amount of zero encodes 32 for lsr and asr
	always_comb begin
		if (by_reg)
			amt = reg_amount[7:0];
		else if (insn[11:7] == 5'd0 && (kind == arm_isa_pkg::lsr || kind == arm_isa_pkg::asr))
			amt = 8'd32;
		else
			amt = {3'b000, insn[11:7]};
	end

	// ------------------------------------------------------------------------
	// widened shifts so the last bit out lands in a fixed place
	// ------------------------------------------------------------------------
	assign lsl_wide = {1'b0, operand} << amt;
	assign lsr_wide = {operand, 1'b0} >> amt;
	assign asr_wide = 33'($signed({operand, 1'b0}) >>> amt);    // fills with sign past 32
	assign ror_res  = (operand >> amt[4:0]) | (operand << (6'd32 - {1'b0, amt[4:0]}));

	always_comb begin
		result    = operand;
		carry_out = carry_in;
		if (amt == 8'd0) begin
			// rrx is the one zero-amount case that moves anything
			if (!by_reg && kind == arm_isa_pkg::ror) begin
				result    = {carry_in, operand[31:1]};
				carry_out = operand[0];
			end
		end else begin
			case (kind)
				arm_isa_pkg::lsl: {carry_out, result} = lsl_wide;
				arm_isa_pkg::lsr: {result, carry_out} = lsr_wide;
				arm_isa_pkg::asr: {result, carry_out} = asr_wide;
				default: begin
					result    = ror_res;
					carry_out = ror_res[31];    // last bit rotated out, also for 32, 64..
				end
			endcase
		end
	end

endmodule

/* logic/arm_decode.sv */
`timescale 1ns/100ps

module arm_decode (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     hold,
	input  logic                     head_valid,
	input  arm_core_pkg::word_t      head_insn,
	input  arm_core_pkg::word_t      head_pc,
	output logic                     pop,
	output arm_core_pkg::reg_sel_t   rd_sel0,
	output arm_core_pkg::reg_sel_t   rd_sel1,
	output arm_core_pkg::reg_sel_t   rd_sel2,
	input  arm_core_pkg::word_t      rd_data0,
	input  arm_core_pkg::word_t      rd_data1,
	input  arm_core_pkg::word_t      rd_data2,
	input  arm_core_pkg::word_t      cps_in,
	output arm_core_pkg::word_t      op0,
	output arm_core_pkg::word_t      op1,
	output arm_core_pkg::word_t      op2,
	output arm_core_pkg::word_t      cps_out,
	output arm_isa_pkg::insn_class_t insn_class,
	output logic                     out_valid
);

	arm_isa_pkg::insn_class_t cls;
	logic                     reg_shift;    // alu_reg with amount in Rs
	logic                     shift_op;     // operand two goes through the shifter
	logic                     shift_carry;
	logic [4:0]               rot_amt;
	arm_core_pkg::word_t      pc_value;
	arm_core_pkg::word_t      rn_val;
	arm_core_pkg::word_t      rm_val;
	arm_core_pkg::word_t      imm8;
	arm_core_pkg::word_t      imm_rot;
	arm_core_pkg::word_t      shift_res;
	arm_core_pkg::word_t      op0_d;
	arm_core_pkg::word_t      op1_d;
	arm_core_pkg::word_t      op2_d;
	arm_core_pkg::word_t      cps_d;

	// ------------------------------------------------------------------------
	// classification, first match wins
	// ------------------------------------------------------------------------
	always_comb begin
		casez (head_insn)
			32'b????_0000_00??_????_????_????_1001_????: cls = arm_isa_pkg::multiply;
			// long multiply, swap and halfword transfers
			32'b????_000?_????_????_????_????_1??1_????: cls = arm_isa_pkg::other;
			// psr transfer and bx sit in the flag-only compare space
			32'b????_00?1_0??0_????_????_????_????_????: cls = arm_isa_pkg::other;
			32'b????_001?_????_????_????_????_????_????: cls = arm_isa_pkg::alu_imm;
			32'b????_000?_????_????_????_????_????_????: cls = arm_isa_pkg::alu_reg;
			32'b????_011?_????_????_????_????_???1_????: cls = arm_isa_pkg::other;    // undefined
			32'b????_01??_????_????_????_????_????_????: cls = arm_isa_pkg::single_xfer;
			32'b????_100?_????_????_????_????_????_????: cls = arm_isa_pkg::block_xfer;
			32'b????_101?_????_????_????_????_????_????: cls = arm_isa_pkg::branch;
			32'b????_1111_????_????_????_????_????_????: cls = arm_isa_pkg::swi;
			default:                                     cls = arm_isa_pkg::other;    // coprocessor
		endcase
	end

	assign reg_shift = (cls == arm_isa_pkg::alu_reg) && head_insn[4];
	// ldr/str use bit 25 set for a register offset
	assign shift_op  = (cls == arm_isa_pkg::alu_reg)
		|| ((cls == arm_isa_pkg::single_xfer) && head_insn[25]);

	// register selection, mla puts its accumulator in bits 15:12
	assign rd_sel0 = (cls == arm_isa_pkg::multiply) ? head_insn[15:12] : head_insn[19:16];
	assign rd_sel1 = head_insn[3:0];
	assign rd_sel2 = head_insn[11:8];

	assign pc_value = head_pc + (reg_shift ? arm_isa_pkg::pc_read_offset_regshift
		: arm_isa_pkg::pc_read_offset);
	assign rn_val   = (rd_sel0 == arm_isa_pkg::pc_reg) ? pc_value : rd_data0;
	assign rm_val   = (rd_sel1 == arm_isa_pkg::pc_reg) ? pc_value : rd_data1;

	// rotated 8-bit immediate
	assign rot_amt = {head_insn[11:8], 1'b0};
	assign imm8    = {24'd0, head_insn[7:0]};
	assign imm_rot = (imm8 >> rot_amt) | (imm8 << (6'd32 - {1'b0, rot_amt}));

	arm_shifter shifter_inst (
		.insn       (head_insn),
		.operand    (rm_val),
		.reg_amount (rd_data2),
		.carry_in   (cps_in[arm_isa_pkg::cbit]),
		.result     (shift_res),
		.carry_out  (shift_carry)
	);

	// ------------------------------------------------------------------------
	// operand forming
	// ------------------------------------------------------------------------
	always_comb begin
		op0_d = '0;
		op1_d = '0;
		op2_d = '0;
		case (cls)
			arm_isa_pkg::alu_imm: begin
				op0_d = rn_val;
				op1_d = imm_rot;
			end
			arm_isa_pkg::alu_reg: begin
				op0_d = rn_val;
				op1_d = shift_res;
				op2_d = reg_shift ? rd_data2 : '0;    // Rs only when it sets the amount
			end
			arm_isa_pkg::single_xfer: begin
				op0_d = rn_val;
				op1_d = head_insn[25] ? shift_res : {20'd0, head_insn[11:0]};
			end
			arm_isa_pkg::block_xfer: begin
				op0_d = rn_val;
				op1_d = {16'd0, head_insn[15:0]};    // register list
			end
			arm_isa_pkg::branch: begin
				op0_d = pc_value;    // branch base, address plus 8
				op1_d = {{6{head_insn[23]}}, head_insn[23:0], 2'b00};
			end
			arm_isa_pkg::multiply: begin
				op0_d = rn_val;      // accumulator
				op1_d = rm_val;
				op2_d = rd_data2;
			end
			default: ;    // swi and other carry zero operands
		endcase
	end

	always_comb begin
		cps_d = cps_in;
		if (shift_op)
			cps_d[arm_isa_pkg::cbit] = shift_carry;
	end

	assign pop = head_valid && !hold;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid  <= 1'b0;
			op0        <= '0;
			op1        <= '0;
			op2        <= '0;
			cps_out    <= '0;
			insn_class <= arm_isa_pkg::alu_imm;    // encodes as zero
		end else begin
			out_valid <= pop;
			if (pop) begin
				op0        <= op0_d;
				op1        <= op1_d;
				op2        <= op2_d;
				cps_out    <= cps_d;
				insn_class <= cls;
			end
		end
	end

endmodule

/* logic/arm_front.sv */
`timescale 1ns/100ps

module arm_front (
	input  logic                     clk,
	input  logic                     rst,
	output arm_core_pkg::word_t      imem_addr,
	input  arm_core_pkg::word_t      imem_data,
	input  logic                     redirect,
	input  arm_core_pkg::word_t      redirect_pc,
	input  logic                     hold,
	input  arm_core_pkg::word_t      cps_in,
	input  logic                     wr_en,
	input  arm_core_pkg::reg_sel_t   wr_sel,
	input  arm_core_pkg::word_t      wr_data,
	output arm_core_pkg::word_t      op0,
	output arm_core_pkg::word_t      op1,
	output arm_core_pkg::word_t      op2,
	output arm_core_pkg::word_t      cps_out,
	output arm_isa_pkg::insn_class_t insn_class,
	output logic                     out_valid
);

	// ------------------------------------------------------------------------
	// fetch to queue
	// ------------------------------------------------------------------------
	logic                   push;
	logic                   full;
	arm_core_pkg::word_t    push_insn;
	arm_core_pkg::word_t    push_pc;

	// queue to decode
	logic                   head_valid;
	logic                   pop;
	arm_core_pkg::word_t    head_insn;
	arm_core_pkg::word_t    head_pc;

	// decode to register file
	arm_core_pkg::reg_sel_t rd_sel0;
	arm_core_pkg::reg_sel_t rd_sel1;
	arm_core_pkg::reg_sel_t rd_sel2;
	arm_core_pkg::word_t    rd_data0;
	arm_core_pkg::word_t    rd_data1;
	arm_core_pkg::word_t    rd_data2;

	arm_fetch fetch_inst (
		.clk         (clk),
		.rst         (rst),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.full        (full),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.push        (push),
		.push_insn   (push_insn),
		.push_pc     (push_pc)
	);

	// redirect doubles as the queue flush
	insn_queue queue_inst (
		.clk        (clk),
		.rst        (rst),
		.flush      (redirect),
		.push       (push),
		.push_insn  (push_insn),
		.push_pc    (push_pc),
		.full       (full),
		.pop        (pop),
		.head_valid (head_valid),
		.head_insn  (head_insn),
		.head_pc    (head_pc)
	);

	arm_regfile regfile_inst (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_sel   (wr_sel),
		.wr_data  (wr_data),
		.rd_sel0  (rd_sel0),
		.rd_sel1  (rd_sel1),
		.rd_sel2  (rd_sel2),
		.rd_data0 (rd_data0),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2)
	);

	arm_decode decode_inst (
		.clk        (clk),
		.rst        (rst),
		.hold       (hold),
		.head_valid (head_valid),
		.head_insn  (head_insn),
		.head_pc    (head_pc),
		.pop        (pop),
		.rd_sel0    (rd_sel0),
		.rd_sel1    (rd_sel1),
		.rd_sel2    (rd_sel2),
		.rd_data0   (rd_data0),
		.rd_data1   (rd_data1),
		.rd_data2   (rd_data2),
		.cps_in     (cps_in),
		.op0        (op0),
		.op1        (op1),
		.op2        (op2),
		.cps_out    (cps_out),
		.insn_class (insn_class),
		.out_valid  (out_valid)
	);

endmodule

/* bench/arm_front_model.svh */
`ifndef ARM_FRONT_MODEL_SVH
`define ARM_FRONT_MODEL_SVH

// shadow copy of r0 .. r14 kept in step with every write through the port
arm_core_pkg::word_t model_regs [15];

function automatic arm_isa_pkg::insn_class_t model_class(input arm_core_pkg::word_t i);
	if (i[27:22] == 6'd0 && i[7:4] == 4'b1001)
		return arm_isa_pkg::multiply;
	if (i[27:25] == 3'b000 && i[7] && i[4])
		return arm_isa_pkg::other;    // long multiply, swap, halfword
	if (i[27:26] == 2'b00 && i[24:23] == 2'b10 && !i[20])
		return arm_isa_pkg::other;    // psr transfer and bx
	if (i[27:25] == 3'b001)
		return arm_isa_pkg::alu_imm;
	if (i[27:25] == 3'b000)
		return arm_isa_pkg::alu_reg;
	if (i[27:25] == 3'b011 && i[4])
		return arm_isa_pkg::other;
	if (i[27:26] == 2'b01)
		return arm_isa_pkg::single_xfer;
	if (i[27:25] == 3'b100)
		return arm_isa_pkg::block_xfer;
	if (i[27:25] == 3'b101)
		return arm_isa_pkg::branch;
	if (i[27:24] == 4'hf)
		return arm_isa_pkg::swi;
	return arm_isa_pkg::other;
endfunction

// ARM operand two shift written out case by case
task automatic model_shift(input arm_core_pkg::word_t i, input arm_core_pkg::word_t v,
		input arm_core_pkg::word_t rs, input logic cin,
		output arm_core_pkg::word_t res, output logic cout);
	int         amt;
	int         r;
	logic [1:0] kind;
	logic       by_reg;
	kind   = i[6:5];
	by_reg = i[4];
	amt    = by_reg ? int'(rs[7:0]) : int'(i[11:7]);
	res    = v;
	cout   = cin;
	if (!by_reg && amt == 0) begin
		case (kind)
			2'd1: begin    // lsr #32
				res  = '0;
				cout = v[31];
			end
			2'd2: begin
				res  = {32{v[31]}};
				cout = v[31];
			end
			2'd3: begin    // rrx
				res  = {cin, v[31:1]};
				cout = v[0];
			end
			default: ;
		endcase
	end else if (amt != 0) begin
		case (kind)
			2'd0: begin
				if (amt < 32) begin
					res  = v << amt;
					cout = v[32 - amt];
				end else begin
					res  = '0;
					cout = (amt == 32) ? v[0] : 1'b0;
				end
			end
			2'd1: begin
				if (amt < 32) begin
					res  = v >> amt;
					cout = v[amt - 1];
				end else begin
					res  = '0;
					cout = (amt == 32) ? v[31] : 1'b0;
				end
			end
			2'd2: begin
				if (amt < 32) begin
					res  = arm_core_pkg::word_t'($signed(v) >>> amt);
					cout = v[amt - 1];
				end else begin
					res  = {32{v[31]}};
					cout = v[31];
				end
			end
			default: begin
				r = amt % 32;
				if (r == 0) begin
					cout = v[31];
				end else begin
					res  = (v >> r) | (v << (32 - r));
					cout = v[r - 1];
				end
			end
		endcase
	end
endtask

// expected class, operands and status word for one instruction
task automatic model_expect(input arm_core_pkg::word_t i, input arm_core_pkg::word_t pc,
		input arm_core_pkg::word_t cps, output arm_isa_pkg::insn_class_t cls,
		output arm_core_pkg::word_t e0, output arm_core_pkg::word_t e1,
		output arm_core_pkg::word_t e2, output arm_core_pkg::word_t ecps);
	logic                reg_shift;
	logic                sc;
	logic [3:0]          rn_sel;
	int                  rot;
	arm_core_pkg::word_t pcv;
	arm_core_pkg::word_t rn;
	arm_core_pkg::word_t rm;
	arm_core_pkg::word_t rs;
	arm_core_pkg::word_t sres;
	arm_core_pkg::word_t imm;
	cls       = model_class(i);
	reg_shift = (cls == arm_isa_pkg::alu_reg) && i[4];
	pcv       = pc + (reg_shift ? 32'd12 : 32'd8);
	rn_sel    = (cls == arm_isa_pkg::multiply) ? i[15:12] : i[19:16];
	if (rn_sel == 4'd15)
		rn = pcv;
	else
		rn = model_regs[rn_sel];
	if (i[3:0] == 4'd15)
		rm = pcv;
	else
		rm = model_regs[i[3:0]];
	if (i[11:8] == 4'd15)
		rs = '0;    // no r15 substitution on the Rs port
	else
		rs = model_regs[i[11:8]];
	model_shift(i, rm, rs, cps[29], sres, sc);
	e0   = '0;
	e1   = '0;
	e2   = '0;
	ecps = cps;
	case (cls)
		arm_isa_pkg::alu_imm: begin
			rot = 2 * int'(i[11:8]);
			imm = {24'd0, i[7:0]};
			e0  = rn;
			e1  = (rot == 0) ? imm : ((imm >> rot) | (imm << (32 - rot)));
		end
		arm_isa_pkg::alu_reg: begin
			e0       = rn;
			e1       = sres;
			e2       = reg_shift ? rs : '0;
			ecps[29] = sc;
		end
		arm_isa_pkg::single_xfer: begin
			e0 = rn;
			if (i[25]) begin
				e1       = sres;
				ecps[29] = sc;
			end else begin
				e1 = {20'd0, i[11:0]};
			end
		end
		arm_isa_pkg::block_xfer: begin
			e0 = rn;
			e1 = {16'd0, i[15:0]};
		end
		arm_isa_pkg::branch: begin
			e0 = pcv;
			e1 = {{6{i[23]}}, i[23:0], 2'b00};
		end
		arm_isa_pkg::multiply: begin
			e0 = rn;
			e1 = rm;
			e2 = rs;
		end
		default: ;
	endcase
endtask

`endif

/* bench/arm_front_tb.sv */
`timescale 1ns/100ps

module arm_front_tb;

	localparam int total_insns = 70;    // every program word fetched including flushed ones

	logic                     clk;
	logic                     rst;
	logic                     redirect;
	logic                     hold;
	logic                     wr_en;
	arm_core_pkg::reg_sel_t   wr_sel;
	arm_core_pkg::word_t      wr_data;
	arm_core_pkg::word_t      redirect_pc;
	arm_core_pkg::word_t      cps_in;
	arm_core_pkg::word_t      imem_addr;
	arm_core_pkg::word_t      imem_data;
	arm_core_pkg::word_t      op0;
	arm_core_pkg::word_t      op1;
	arm_core_pkg::word_t      op2;
	arm_core_pkg::word_t      cps_out;
	arm_isa_pkg::insn_class_t insn_class;
	logic                     out_valid;

	arm_core_pkg::word_t imem [1024];
	integer              seed;
	int                  err_count;
	int                  tests_ok;
	int                  tests_bad;

	`include "arm_front_model.svh"

	arm_front arm_front_inst (
		.clk         (clk),
		.rst         (rst),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.hold        (hold),
		.cps_in      (cps_in),
		.wr_en       (wr_en),
		.wr_sel      (wr_sel),
		.wr_data     (wr_data),
		.op0         (op0),
		.op1         (op1),
		.op2         (op2),
		.cps_out     (cps_out),
		.insn_class  (insn_class),
		.out_valid   (out_valid)
	);

	assign imem_data = imem[imem_addr[11:2]];    // combinational instruction memory

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#(total_insns * 20 * 40);
		$display("timeout: the tests did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------
	task automatic check_word(input string name, input arm_core_pkg::word_t exp,
			input arm_core_pkg::word_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_class(input string name, input arm_isa_pkg::insn_class_t exp,
			input arm_isa_pkg::insn_class_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
			err_count++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			$display("test %s ok", name);
			tests_ok++;
		end else begin
			$display("test %s failed with %0d errors", name, err_count - errs_before);
			tests_bad++;
		end
	endtask

	// ------------------------------------------------------------------------
	// instruction builders with condition always
	// ------------------------------------------------------------------------
	function automatic arm_core_pkg::word_t alu_imm_word(input logic [3:0] opc,
			input logic [3:0] rn, input logic [3:0] rot, input logic [7:0] imm8);
		return {4'he, 3'b001, opc, 1'b1, rn, 4'd1, rot, imm8};
	endfunction

	function automatic arm_core_pkg::word_t shift_imm_word(input logic [3:0] opc,
			input logic [3:0] rn, input logic [4:0] amt, input logic [1:0] kind,
			input logic [3:0] rm);
		return {4'he, 3'b000, opc, 1'b1, rn, 4'd2, amt, kind, 1'b0, rm};
	endfunction

	function automatic arm_core_pkg::word_t shift_reg_word(input logic [3:0] opc,
			input logic [3:0] rn, input logic [3:0] rs, input logic [1:0] kind,
			input logic [3:0] rm);
		return {4'he, 3'b000, opc, 1'b1, rn, 4'd3, rs, 1'b0, kind, 1'b1, rm};
	endfunction

	task automatic write_reg(input logic [3:0] sel, input arm_core_pkg::word_t val);
		wr_en           = 1'b1;
		wr_sel          = sel;
		wr_data         = val;
		model_regs[sel] = val;
		@(posedge clk);
		#2;
		wr_en = 1'b0;
	endtask

	// random registers then fixed low bytes in r10 .. r13 for register shifts
	task automatic load_regs();
		arm_core_pkg::word_t r;
		for (int s = 0; s < 15; s++)
			write_reg(s[3:0], $random(seed));
		r = $random(seed);
		write_reg(4'd10, {r[31:8], 8'd0});
		write_reg(4'd11, {r[23:0], 8'd32});
		write_reg(4'd12, {r[27:4], 8'd47});
		write_reg(4'd13, {r[31:8], 3'd0, r[4:0]});
		cps_in = $random(seed);
	endtask

	task automatic rand_alu_word(output arm_core_pkg::word_t w);
		arm_core_pkg::word_t r;
		r = $random(seed);
		case (r[31:30])
			2'd0:    w = alu_imm_word(r[3:0], r[7:4], r[11:8], r[19:12]);
			2'd1:    w = shift_reg_word(r[3:0], r[7:4], 4'd13, r[9:8], {1'b0, r[14:12]});
			default: w = shift_imm_word(r[3:0], r[7:4], r[12:8], r[14:13], {1'b0, r[18:16]});
		endcase
	endtask

	// redirect to start and optionally hold before collecting n results in order
	task automatic run_prog(input string name, input arm_core_pkg::word_t start,
			input int n, input int pre_hold);
		int                       got;
		int                       cyc;
		arm_core_pkg::word_t      pc;
		arm_core_pkg::word_t      e0;
		arm_core_pkg::word_t      e1;
		arm_core_pkg::word_t      e2;
		arm_core_pkg::word_t      ecps;
		arm_isa_pkg::insn_class_t ecls;
		redirect    = 1'b1;
		redirect_pc = start;
		hold        = (pre_hold > 0);
		@(posedge clk);
		#2;
		redirect = 1'b0;
		check_word($sformatf("%s.imem_addr", name), start, imem_addr);    // pc took the target
		for (int h = 0; h < pre_hold; h++) begin
			@(negedge clk);
			if (out_valid)
				$display("%s: out_valid rose while hold was high", name);
			if (out_valid)
				err_count++;
			@(posedge clk);
			#2;
		end
		hold = 1'b0;
		got  = 0;
		cyc  = 0;
		while (got < n && cyc < n * 20 + 10) begin
			@(negedge clk);    // outputs settle well before the falling edge
			if (out_valid) begin
				pc = start + 32'(4 * got);
				model_expect(imem[pc[11:2]], pc, cps_in, ecls, e0, e1, e2, ecps);
				check_class($sformatf("%s[%0d].class", name, got), ecls, insn_class);
				check_word($sformatf("%s[%0d].op0", name, got), e0, op0);
				check_word($sformatf("%s[%0d].op1", name, got), e1, op1);
				check_word($sformatf("%s[%0d].op2", name, got), e2, op2);
				check_word($sformatf("%s[%0d].cps", name, got), ecps, cps_out);
				got++;
			end
			cyc++;
		end
		if (got < n) begin
			$display("%s: only %0d of %0d results came out", name, got, n);
			err_count++;
		end
		@(posedge clk);
		#2;
		hold = 1'b1;
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic reset_test();
		int errs;
		errs = err_count;
		repeat (4) begin
			@(negedge clk);
			check_word("reset out_valid", 32'd0, {31'd0, out_valid});
			check_word("reset imem_addr", 32'd0, imem_addr);
			check_word("reset op0", 32'd0, op0);
			check_word("reset op1", 32'd0, op1);
			check_word("reset op2", 32'd0, op2);
			check_word("reset cps", 32'd0, cps_out);
			check_class("reset class", arm_isa_pkg::insn_class_t'(3'd0), insn_class);
		end
		@(posedge clk);
		#2;
		finish_test("reset", errs);
	endtask

	task automatic alu_test();
		int                  errs;
		int                  idx;
		arm_core_pkg::word_t r;
		errs = err_count;
		idx  = 32'h40 >> 2;
		load_regs();
		for (int k = 0; k < 4; k++) begin
			r = $random(seed);
			imem[idx]     = alu_imm_word(r[3:0], r[7:4], r[11:8], r[19:12]);
			imem[idx + 1] = shift_imm_word(r[3:0], r[7:4], 5'd0, k[1:0], {1'b0, r[22:20]});
			imem[idx + 2] = shift_imm_word(r[3:0], r[7:4], r[27:23], k[1:0], {1'b0, r[30:28]});
			for (int s = 0; s < 4; s++)
				imem[idx + 3 + s] = shift_reg_word(r[3:0], r[7:4], 4'(10 + s), k[1:0],
					{1'b0, r[14:12]});
			idx = idx + 7;
		end
		run_prog("alu", 32'h40, 28, 0);
		finish_test("alu", errs);
	endtask

	task automatic r15_test();
		int                  errs;
		arm_core_pkg::word_t r;
		errs = err_count;
		load_regs();
		r = $random(seed);
		imem[64] = alu_imm_word(4'h4, 4'd15, r[3:0], r[11:4]);
		imem[65] = shift_imm_word(4'h4, 4'd15, r[16:12], 2'd0, 4'd3);
		imem[66] = shift_imm_word(4'h2, 4'd2, r[21:17], 2'd1, 4'd15);
		imem[67] = shift_reg_word(4'h4, 4'd15, 4'd13, 2'd0, 4'd15);
		imem[68] = {4'he, 3'b010, 5'b11001, 4'd15, 4'd0, r[31:20]};    // ldr pc-relative
		imem[69] = shift_imm_word(4'h4, 4'd4, r[26:22], 2'd2, 4'd5);
		run_prog("r15", 32'h100, 6, 0);
		finish_test("r15", errs);
	endtask

	task automatic class_test();
		int                  errs;
		arm_core_pkg::word_t r;
		errs = err_count;
		load_regs();
		r = $random(seed);
		imem[128] = {4'he, 3'b101, 1'b0, 24'h00_0123};
		imem[129] = {4'he, 3'b101, 1'b1, 24'hff_fff0};    // bl backwards
		imem[130] = {4'he, 3'b100, 5'b01001, r[19:16], r[15:0]};
		imem[131] = {4'he, 3'b010, 5'b11001, r[23:20], 4'd0, r[11:0]};
		imem[132] = {4'he, 3'b011, 5'b11001, r[27:24], 4'd0, r[16:12], r[6:5], 1'b0, 4'd6};
		imem[133] = {4'he, 6'd0, 1'b0, 1'b1, 4'd7, 4'd0, 4'd8, 4'b1001, 4'd9};
		imem[134] = {4'he, 6'd0, 1'b1, 1'b1, 4'd7, 4'd11, 4'd12, 4'b1001, 4'd14};
		imem[135] = {4'he, 4'hf, r[23:0]};
		imem[136] = {4'he, 3'b011, r[19:0], 1'b1, r[31:28]};    // undefined
		imem[137] = {4'he, 4'b1110, r[27:4]};                    // coprocessor
		run_prog("class", 32'h200, 10, 0);
		finish_test("class", errs);
	endtask

	task automatic hold_test();
		int errs;
		errs = err_count;
		load_regs();
		for (int k = 0; k < 10; k++)
			rand_alu_word(imem[192 + k]);
		run_prog("hold", 32'h300, 10, 12);
		finish_test("hold", errs);
	endtask

	// the queue fills from one program before a redirect leaves for another
	task automatic flush_test();
		int errs;
		errs = err_count;
		load_regs();
		for (int k = 0; k < 8; k++) begin
			rand_alu_word(imem[256 + k]);
			rand_alu_word(imem[320 + k]);
		end
		redirect    = 1'b1;
		redirect_pc = 32'h400;
		@(posedge clk);
		#2;
		redirect = 1'b0;
		repeat (8) begin
			@(negedge clk);
			if (out_valid) begin
				$display("flush: out_valid rose while hold was high");
				err_count++;
			end
			@(posedge clk);
			#2;
		end
		run_prog("flush", 32'h500, 8, 0);
		finish_test("flush", errs);
	endtask

	initial begin
		arm_core_pkg::word_t addr;
		seed        = 32'h2e62;
		err_count   = 0;
		tests_ok    = 0;
		tests_bad   = 0;
		rst         = 1'b1;
		redirect    = 1'b0;
		redirect_pc = '0;
		hold        = 1'b1;
		cps_in      = '0;
		wr_en       = 1'b0;
		wr_sel      = '0;
		wr_data     = '0;
		for (int i = 0; i < 1024; i++) begin
			addr    = 32'(i * 4);
			imem[i] = (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
		end
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		reset_test();
		alu_test();
		r15_test();
		class_test();
		hold_test();
		flush_test();
		$display("tests passed %0d failed %0d", tests_ok, tests_bad);
		if (err_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* arm_front.f */
+incdir+bench
logic/arm_isa_pkg.sv
logic/arm_core_pkg.sv
logic/arm_fetch.sv
logic/insn_queue.sv
logic/arm_regfile.sv
logic/arm_shifter.sv
logic/arm_decode.sv
logic/arm_front.sv
bench/arm_front_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and judge the run by the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module arm_front_tb -f arm_front.f -o arm_front_sim || exit 1
out=$(./obj_dir/arm_front_sim)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" && exit 0 || exit 1
